/* hw/video_timing_pkg.sv */
// raster counter widths, tile geometry and output pipeline depth
package video_timing_pkg;

    // raster counters
    localparam int H_COUNT_W = 10;  // pixels per line incl. blanking
    localparam int V_COUNT_W = 9;   // lines per frame incl. blanking

    // tile geometry
    localparam int TILE_PX    = 8;
    localparam int TILE_SHIFT = 3;  // log2 of tile edge

    // one VRAM access per cycle, eight per tile
    localparam int TILE_SLOTS = 8;

    // raw raster signals to pins
    localparam int PIPE_DELAY = 2;

endpackage

/* hw/tile_map_pkg.sv */
// VRAM layout, fetch slot encoding, RGB332 pixel and VRAM32 word types
package tile_map_pkg;

    localparam int VRAM_ADDR_W = 14;

    // VRAM8 regions
    localparam int BG_MAP_BASE    = 0;
    localparam int BG_COLOR_BASE  = 2048;
    localparam int WIN_MAP_BASE   = 4096;
    localparam int WIN_COLOR_BASE = 6144;
    localparam int SCROLL_ADDR    = 8192;

    // VRAM32 regions
    localparam int PALETTE_BASE           = 1024;
    localparam int PATTERN_WORDS_PER_TILE = 4;  // two rows per word

    localparam int BG_MAP_STRIDE = 64;  // wider than the screen, room to scroll

    typedef enum logic [2:0] {
        BG_TILE,
        BG_PATTERN,
        BG_COLOR,
        BG_PALETTE,
        WIN_TILE,
        WIN_PATTERN,
        WIN_COLOR,
        WIN_PALETTE
    } fetch_slot_e;

    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [1:0] blue;
    } rgb332_t;

    // one VRAM32 word is either two pattern rows or a 4-entry palette
    typedef union packed {
        struct packed {
            logic [15:0] odd_row;
            logic [15:0] even_row;  // leftmost pixel in bits 15:14
        } pattern;
        rgb332_t [0:3] palette;  // entry 0 in bits 31:24
    } vram32_word_u;

    typedef rgb332_t [0:7] pixel_row_t;  // element 0 is the leftmost pixel

endpackage

/* hw/raster_timing.sv */
// raster timing: pixel and line counters, syncs, data enable, fetch lookahead
`timescale 1ns/1ps

module raster_timing #(
    parameter int H_RES  = 320,
    parameter int V_RES  = 200,
    parameter int H_FP   = 34,
    parameter int H_SYNC = 32,
    parameter int H_BP   = 56,
    parameter int V_FP   = 23,
    parameter int V_SYNC = 5,
    parameter int V_BP   = 34
) (
    input  logic                                   vga_clk,
    input  logic                                   i_reset,
    output logic                                   o_hsync_raw,
    output logic                                   o_vsync_raw,
    output logic                                   o_de_raw,
    output logic                                   o_fetch_en,
    output logic                                   o_frame_start,
    output logic [video_timing_pkg::H_COUNT_W-1:0] o_fetch_x,
    output logic [video_timing_pkg::V_COUNT_W-1:0] o_fetch_y,
    output tile_map_pkg::fetch_slot_e              o_slot
);

    localparam int HW      = video_timing_pkg::H_COUNT_W;
    localparam int VW      = video_timing_pkg::V_COUNT_W;
    localparam int TS      = video_timing_pkg::TILE_SHIFT;
    localparam int LEAD    = video_timing_pkg::TILE_SLOTS;
    localparam int HA_STA  = H_FP + H_SYNC + H_BP;
    localparam int H_TOTAL = HA_STA + H_RES;
    localparam int VA_STA  = V_FP + V_SYNC + V_BP;
    localparam int V_TOTAL = VA_STA + V_RES;

    logic [HW-1:0] h_count;
    logic [VW-1:0] v_count;
    logic [HW-1:0] look_x;
    logic          v_active;

    always_ff @(posedge vga_clk) begin
        if (i_reset) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == HW'(H_TOTAL - 1)) begin
            h_count <= '0;
            if (v_count == VW'(V_TOTAL - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    assign v_active = (v_count >= VW'(VA_STA));

    // syncs are active low
    assign o_hsync_raw = !((h_count >= HW'(H_FP)) && (h_count < HW'(H_FP + H_SYNC)));
    assign o_vsync_raw = !((v_count >= VW'(V_FP)) && (v_count < VW'(V_FP + V_SYNC)));
    assign o_de_raw    = (h_count >= HW'(HA_STA)) && v_active;

    assign o_frame_start = (v_count == VW'(V_FP)) && (h_count == '0);  // first vsync cycle

    // column one tile ahead of the beam, wraps in the porches
    assign look_x = h_count + HW'(LEAD) - HW'(HA_STA);

    assign o_fetch_en = v_active && (h_count >= HW'(HA_STA - LEAD))
                        && (h_count < HW'(H_TOTAL - LEAD));
    assign o_fetch_x  = look_x;
    assign o_fetch_y  = v_count - VW'(VA_STA);
    assign o_slot     = tile_map_pkg::fetch_slot_e'(look_x[TS-1:0]);

endmodule

/* hw/tile_fetch_sequencer.sv */
// tile fetch sequencer: per-slot VRAM8 and VRAM32 addresses, scroll register
`timescale 1ns/1ps

module tile_fetch_sequencer #(
    parameter int H_RES = 320
) (
    input  logic                                   vga_clk,
    input  logic                                   i_reset,
    input  logic                                   i_fetch_en,
    input  logic                                   i_frame_start,
    input  logic [video_timing_pkg::H_COUNT_W-1:0] i_fetch_x,
    input  logic [video_timing_pkg::V_COUNT_W-1:0] i_fetch_y,
    input  tile_map_pkg::fetch_slot_e              i_slot,
    input  logic [7:0]                             i_vram8_q,
    output logic [tile_map_pkg::VRAM_ADDR_W-1:0]   o_vram8_addr,
    output logic [tile_map_pkg::VRAM_ADDR_W-1:0]   o_vram32_addr,
    output tile_map_pkg::fetch_slot_e              o_slot_d,
    output logic                                   o_odd_row
);

    localparam int AW         = tile_map_pkg::VRAM_ADDR_W;
    localparam int HW         = video_timing_pkg::H_COUNT_W;
    localparam int VW         = video_timing_pkg::V_COUNT_W;
    localparam int TS         = video_timing_pkg::TILE_SHIFT;
    localparam int SCROLL_W   = $clog2(tile_map_pkg::BG_MAP_STRIDE);
    localparam int WIN_STRIDE = H_RES / video_timing_pkg::TILE_PX;

    logic [HW-TS-1:0]    tile_col;
    logic [VW-TS-1:0]    tile_row;
    logic [TS-1:0]       row_in_tile;
    logic [SCROLL_W-1:0] scroll;
    logic [SCROLL_W-1:0] bg_col;
    logic [AW-1:0]       bg_index;
    logic [AW-1:0]       win_index;
    logic                frame_start_d;

    assign tile_col    = i_fetch_x[HW-1:TS];
    assign tile_row    = i_fetch_y[VW-1:TS];
    assign row_in_tile = i_fetch_y[TS-1:0];

    assign bg_col    = tile_col[SCROLL_W-1:0] + scroll;  // wraps at map stride
    assign bg_index  = AW'(tile_row * tile_map_pkg::BG_MAP_STRIDE + bg_col);
    assign win_index = AW'(tile_row * WIN_STRIDE + tile_col);

    // VRAM8 data of the previous slot is on i_vram8_q during pattern and palette slots
    always_comb begin
        o_vram8_addr  = '0;
        o_vram32_addr = '0;
        if (i_frame_start) begin
            o_vram8_addr = AW'(tile_map_pkg::SCROLL_ADDR);
        end else if (i_fetch_en) begin
            case (i_slot)
                tile_map_pkg::BG_TILE:
                    o_vram8_addr = AW'(tile_map_pkg::BG_MAP_BASE + bg_index);
                tile_map_pkg::BG_COLOR:
                    o_vram8_addr = AW'(tile_map_pkg::BG_COLOR_BASE + bg_index);
                tile_map_pkg::WIN_TILE:
                    o_vram8_addr = AW'(tile_map_pkg::WIN_MAP_BASE + win_index);
                tile_map_pkg::WIN_COLOR:
                    o_vram8_addr = AW'(tile_map_pkg::WIN_COLOR_BASE + win_index);
                tile_map_pkg::BG_PATTERN, tile_map_pkg::WIN_PATTERN:
                    o_vram32_addr = AW'(i_vram8_q * tile_map_pkg::PATTERN_WORDS_PER_TILE
                                        + row_in_tile[TS-1:1]);
                tile_map_pkg::BG_PALETTE, tile_map_pkg::WIN_PALETTE:
                    o_vram32_addr = AW'(tile_map_pkg::PALETTE_BASE + i_vram8_q);
            endcase
        end
    end

    always_ff @(posedge vga_clk) begin
        if (i_reset) begin
            o_slot_d      <= tile_map_pkg::BG_TILE;
            o_odd_row     <= 1'b0;
            frame_start_d <= 1'b0;
            scroll        <= '0;
        end else begin
            o_slot_d      <= i_slot;
            o_odd_row     <= row_in_tile[0];  // follows the pattern word into VRAM32
            frame_start_d <= i_frame_start;
            if (frame_start_d) begin
                scroll <= i_vram8_q[SCROLL_W-1:0];  // tile offset for the coming frame
            end
        end
    end

endmodule

/* hw/tile_row_decoder.sv */
// tile row decoder: pattern row capture and palette expansion to RGB332 rows
`timescale 1ns/1ps

module tile_row_decoder (
    input  logic                        vga_clk,
    input  logic                        i_reset,
    input  tile_map_pkg::fetch_slot_e   i_slot_d,
    input  logic                        i_odd_row,
    input  tile_map_pkg::vram32_word_u  i_vram32_q,
    output tile_map_pkg::pixel_row_t    o_bg_row,
    output tile_map_pkg::pixel_row_t    o_win_row,
    output logic                        o_row_valid
);

    logic [15:0] bg_pattern;
    logic [15:0] win_pattern;
    logic [15:0] pattern_row;

    // eight 2-bit indices, leftmost pixel in the top pair
    function automatic tile_map_pkg::pixel_row_t expand_row(
        input logic [15:0]               pattern,
        input tile_map_pkg::vram32_word_u pal
    );
        tile_map_pkg::pixel_row_t row;
        int                       i;
        for (i = 0; i < video_timing_pkg::TILE_PX; i++) begin
            row[i] = pal.palette[pattern[15 - 2*i -: 2]];
        end
        return row;
    endfunction

    assign pattern_row = i_odd_row ? i_vram32_q.pattern.odd_row
                                   : i_vram32_q.pattern.even_row;

    always_ff @(posedge vga_clk) begin
        if (i_reset) begin
            bg_pattern  <= '0;
            win_pattern <= '0;
            o_bg_row    <= '0;
        end else begin
            case (i_slot_d)
                tile_map_pkg::BG_PATTERN:  bg_pattern <= pattern_row;
                tile_map_pkg::WIN_PATTERN: win_pattern <= pattern_row;
                tile_map_pkg::BG_PALETTE:  o_bg_row <= expand_row(bg_pattern, i_vram32_q);
                default: ;
            endcase
        end
    end

    // window palette is on the bus in the first pixel cycle of the tile
    assign o_win_row   = expand_row(win_pattern, i_vram32_q);
    assign o_row_valid = (i_slot_d == tile_map_pkg::WIN_PALETTE);

endmodule

/* hw/plane_mixer.sv */
// plane mixer: displayed row buffers, window priority, output pipeline
`timescale 1ns/1ps

module plane_mixer (
    input  logic                     vga_clk,
    input  logic                     i_reset,
    input  logic                     i_row_valid,
    input  logic                     i_hsync_raw,
    input  logic                     i_vsync_raw,
    input  logic                     i_de_raw,
    input  tile_map_pkg::pixel_row_t i_bg_row,
    input  tile_map_pkg::pixel_row_t i_win_row,
    output logic                     o_hsync,
    output logic                     o_vsync,
    output logic                     o_de,
    output tile_map_pkg::rgb332_t    o_rgb
);

    localparam int PD = video_timing_pkg::PIPE_DELAY;
    localparam int TS = video_timing_pkg::TILE_SHIFT;

    tile_map_pkg::pixel_row_t         bg_buf;
    tile_map_pkg::pixel_row_t         win_buf;
    logic [TS-1:0]                    pix_idx;
    tile_map_pkg::rgb332_t            bg_px;
    tile_map_pkg::rgb332_t            win_px;
    tile_map_pkg::rgb332_t            out_px;
    logic [PD-1:0]                    hs_pipe;
    logic [PD-1:0]                    vs_pipe;
    logic [PD-1:0]                    de_pipe;
    tile_map_pkg::rgb332_t [PD-1:0]   rgb_pipe;

    // pixel 0 comes straight from the decoder in the load cycle
    assign bg_px  = i_row_valid ? i_bg_row[0] : bg_buf[pix_idx];
    assign win_px = i_row_valid ? i_win_row[0] : win_buf[pix_idx];
    assign out_px = !i_de_raw ? 8'h00 : (win_px != 8'h00) ? win_px : bg_px;  // window on top

    always_ff @(posedge vga_clk) begin
        if (i_row_valid) begin
            bg_buf  <= i_bg_row;
            win_buf <= i_win_row;
        end
    end

    always_ff @(posedge vga_clk) begin
        if (i_reset) begin
            pix_idx  <= '0;
            hs_pipe  <= '1;
            vs_pipe  <= '1;
            de_pipe  <= '0;
            rgb_pipe <= '0;
        end else begin
            pix_idx  <= i_row_valid ? TS'(1) : pix_idx + 1'b1;
            hs_pipe  <= {hs_pipe[PD-2:0], i_hsync_raw};
            vs_pipe  <= {vs_pipe[PD-2:0], i_vsync_raw};
            de_pipe  <= {de_pipe[PD-2:0], i_de_raw};
            rgb_pipe <= {rgb_pipe[PD-2:0], out_px};
        end
    end

    assign o_hsync = hs_pipe[PD-1];
    assign o_vsync = vs_pipe[PD-1];
    assign o_de    = de_pipe[PD-1];
    assign o_rgb   = rgb_pipe[PD-1];

endmodule

/* hw/bgw_renderer_top.sv */
// background and window tile renderer top level
`timescale 1ns/1ps

module bgw_renderer_top #(
    parameter int H_RES  = 320,
    parameter int V_RES  = 200,
    parameter int H_FP   = 34,
    parameter int H_SYNC = 32,
    parameter int H_BP   = 56,
    parameter int V_FP   = 23,
    parameter int V_SYNC = 5,
    parameter int V_BP   = 34
) (
    input  logic                                 vga_clk,
    input  logic                                 i_reset,
    input  logic [7:0]                           i_vram8_q,
    input  logic [31:0]                          i_vram32_q,
    output logic [tile_map_pkg::VRAM_ADDR_W-1:0] o_vram8_addr,
    output logic [tile_map_pkg::VRAM_ADDR_W-1:0] o_vram32_addr,
    output logic                                 o_hsync,
    output logic                                 o_vsync,
    output logic                                 o_de,
    output tile_map_pkg::rgb332_t                o_rgb
);

    logic                                   hsync_raw;
    logic                                   vsync_raw;
    logic                                   de_raw;
    logic                                   fetch_en;
    logic                                   frame_start;
    logic [video_timing_pkg::H_COUNT_W-1:0] fetch_x;
    logic [video_timing_pkg::V_COUNT_W-1:0] fetch_y;
    tile_map_pkg::fetch_slot_e              slot;
    tile_map_pkg::fetch_slot_e              slot_d;
    logic                                   odd_row;
    tile_map_pkg::pixel_row_t               bg_row;
    tile_map_pkg::pixel_row_t               win_row;
    logic                                   row_valid;

    raster_timing #(
        .H_RES (H_RES),
        .V_RES (V_RES),
        .H_FP  (H_FP),
        .H_SYNC(H_SYNC),
        .H_BP  (H_BP),
        .V_FP  (V_FP),
        .V_SYNC(V_SYNC),
        .V_BP  (V_BP)
    ) u_raster (
        .vga_clk      (vga_clk),
        .i_reset      (i_reset),
        .o_hsync_raw  (hsync_raw),
        .o_vsync_raw  (vsync_raw),
        .o_de_raw     (de_raw),
        .o_fetch_en   (fetch_en),
        .o_frame_start(frame_start),
        .o_fetch_x    (fetch_x),
        .o_fetch_y    (fetch_y),
        .o_slot       (slot)
    );

    tile_fetch_sequencer #(
        .H_RES(H_RES)
    ) u_fetch (
        .vga_clk      (vga_clk),
        .i_reset      (i_reset),
        .i_fetch_en   (fetch_en),
        .i_frame_start(frame_start),
        .i_fetch_x    (fetch_x),
        .i_fetch_y    (fetch_y),
        .i_slot       (slot),
        .i_vram8_q    (i_vram8_q),
        .o_vram8_addr (o_vram8_addr),
        .o_vram32_addr(o_vram32_addr),
        .o_slot_d     (slot_d),
        .o_odd_row    (odd_row)
    );

    tile_row_decoder u_decode (
        .vga_clk    (vga_clk),
        .i_reset    (i_reset),
        .i_slot_d   (slot_d),
        .i_odd_row  (odd_row),
        .i_vram32_q (i_vram32_q),
        .o_bg_row   (bg_row),
        .o_win_row  (win_row),
        .o_row_valid(row_valid)
    );

    plane_mixer u_mixer (
        .vga_clk    (vga_clk),
        .i_reset    (i_reset),
        .i_row_valid(row_valid),
        .i_hsync_raw(hsync_raw),
        .i_vsync_raw(vsync_raw),
        .i_de_raw   (de_raw),
        .i_bg_row   (bg_row),
        .i_win_row  (win_row),
        .o_hsync    (o_hsync),
        .o_vsync    (o_vsync),
        .o_de       (o_de),
        .o_rgb      (o_rgb)
    );

endmodule

/* verification/bgw_renderer_properties.sv */
// concurrent assertions on the renderer video outputs
`timescale 1ns/1ps

module bgw_renderer_properties #(
    parameter int H_SYNC = 32
) (
    input logic                  vga_clk,
    input logic                  i_reset,
    input logic                  i_hsync,
    input logic                  i_vsync,
    input logic                  i_de,
    input tile_map_pkg::rgb332_t i_rgb
);

    int fail_count;  // failed assertion count

    // blanking is black
    rgb_zero_outside_de: assert property (
        @(posedge vga_clk) disable iff (i_reset)
        !i_de |-> (i_rgb == 8'h00)
    ) else begin
        fail_count++;
        $error("o_rgb nonzero while o_de is low");
    end

    hsync_pulse_width: assert property (
        @(posedge vga_clk) disable iff (i_reset)
        $fell(i_hsync) |-> !i_hsync [*H_SYNC] ##1 i_hsync
    ) else begin
        fail_count++;
        $error("o_hsync low pulse is not %0d cycles wide", H_SYNC);
    end

    // active video only starts outside both syncs
    de_rise_outside_sync: assert property (
        @(posedge vga_clk) disable iff (i_reset)
        $rose(i_de) |-> (i_hsync && i_vsync)
    ) else begin
        fail_count++;
        $error("o_de rose during a sync pulse");
    end

endmodule

/* verification/bgw_renderer_tb.sv */
// testbench for the tile renderer: VRAM models, reference model, pixel and address checks
`timescale 1ns/1ps

module bgw_renderer_tb;

    localparam int H_RES          = 64;
    localparam int V_RES          = 16;
    localparam int H_FP           = 4;
    localparam int H_SYNC         = 8;
    localparam int H_BP           = 12;
    localparam int V_FP           = 2;
    localparam int V_SYNC         = 2;
    localparam int V_BP           = 2;
    localparam int AW             = tile_map_pkg::VRAM_ADDR_W;
    localparam int TP             = video_timing_pkg::TILE_PX;
    localparam int LINE_CYCLES    = H_FP + H_SYNC + H_BP + H_RES;
    localparam int FRAME_CYCLES   = LINE_CYCLES * (V_FP + V_SYNC + V_BP + V_RES);
    localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES * 11 / 10;
    localparam int FRAME_PIXELS   = H_RES * V_RES;
    localparam int MAP_SPAN       = 2048;  // size of each VRAM8 map region
    localparam int PALETTE_COUNT  = 64;
    localparam int SCROLL_TILES   = 61;    // wraps the map inside a line
    localparam int DRIVE_DELAY    = 1;

    logic                  vga_clk;
    logic                  i_reset;
    logic [7:0]            i_vram8_q;
    logic [31:0]           i_vram32_q;
    logic [AW-1:0]         o_vram8_addr;
    logic [AW-1:0]         o_vram32_addr;
    logic                  o_hsync;
    logic                  o_vsync;
    logic                  o_de;
    tile_map_pkg::rgb332_t o_rgb;

    logic [7:0]  vram8 [0:(1 << AW) - 1];
    logic [31:0] vram32 [0:(1 << AW) - 1];
    logic [31:0] lcg_state;
    int          pix_count;
    int          addr_checks;
    int          cycle_count;

    bgw_renderer_top #(
        .H_RES (H_RES),
        .V_RES (V_RES),
        .H_FP  (H_FP),
        .H_SYNC(H_SYNC),
        .H_BP  (H_BP),
        .V_FP  (V_FP),
        .V_SYNC(V_SYNC),
        .V_BP  (V_BP)
    ) uut (
        .vga_clk      (vga_clk),
        .i_reset      (i_reset),
        .i_vram8_q    (i_vram8_q),
        .i_vram32_q   (i_vram32_q),
        .o_vram8_addr (o_vram8_addr),
        .o_vram32_addr(o_vram32_addr),
        .o_hsync      (o_hsync),
        .o_vsync      (o_vsync),
        .o_de         (o_de),
        .o_rgb        (o_rgb)
    );

    bind bgw_renderer_top bgw_renderer_properties #(.H_SYNC(H_SYNC)) u_props (
        .vga_clk(vga_clk),
        .i_reset(i_reset),
        .i_hsync(o_hsync),
        .i_vsync(o_vsync),
        .i_de   (o_de),
        .i_rgb  (o_rgb)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [AW-1:0] bg_map_addr(input int base, input int x, input int y,
                                                  input int scroll);
        return AW'(base + (y / TP) * tile_map_pkg::BG_MAP_STRIDE
                   + (x / TP + scroll) % tile_map_pkg::BG_MAP_STRIDE);
    endfunction

    function automatic logic [AW-1:0] win_map_addr(input int base, input int x, input int y);
        return AW'(base + (y / TP) * (H_RES / TP) + x / TP);
    endfunction

    // one plane's colour at (x, y) for a given tile and palette
    function automatic tile_map_pkg::rgb332_t plane_pixel(input int tile, input int colour,
                                                          input int x, input int y);
        logic [31:0] word;
        logic [15:0] row;
        int          idx;
        word = vram32[tile * tile_map_pkg::PATTERN_WORDS_PER_TILE + (y % TP) / 2];
        row  = (y % 2 == 1) ? word[31:16] : word[15:0];
        idx  = row[15 - 2 * (x % TP) -: 2];  // leftmost pixel in the top pair
        word = vram32[tile_map_pkg::PALETTE_BASE + colour];
        return word[31 - 8 * idx -: 8];
    endfunction

    function automatic tile_map_pkg::rgb332_t expected_pixel(input int x, input int y,
                                                             input int scroll);
        tile_map_pkg::rgb332_t bg;
        tile_map_pkg::rgb332_t win;
        bg  = plane_pixel(vram8[bg_map_addr(tile_map_pkg::BG_MAP_BASE, x, y, scroll)],
                          vram8[bg_map_addr(tile_map_pkg::BG_COLOR_BASE, x, y, scroll)], x, y);
        win = plane_pixel(vram8[win_map_addr(tile_map_pkg::WIN_MAP_BASE, x, y)],
                          vram8[win_map_addr(tile_map_pkg::WIN_COLOR_BASE, x, y)], x, y);
        return (win != 8'h00) ? win : bg;  // window on top unless black
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
        $display("Test failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_rgb(input string name, input tile_map_pkg::rgb332_t expected,
                             input tile_map_pkg::rgb332_t actual);
        if (actual !== expected) begin
            report_mismatch(name, 32'(expected), 32'(actual));
        end
    endtask

    task automatic check_addr(input string name, input logic [AW-1:0] expected,
                              input logic [AW-1:0] actual);
        if (actual !== expected) begin
            report_mismatch(name, 32'(expected), 32'(actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_mismatch(name, 32'(expected), 32'(actual));
        end
    endtask

    task automatic fill_vram();
        int a;
        for (a = 0; a < (1 << AW); a++) begin
            lcg_state = lcg_step(lcg_state);
            vram8[a]  = lcg_state[23:16];
            lcg_state = lcg_step(lcg_state);
            vram32[a] = lcg_state;
        end
        for (a = 0; a < MAP_SPAN; a++) begin
            vram8[tile_map_pkg::BG_COLOR_BASE + a]  = vram8[tile_map_pkg::BG_COLOR_BASE + a]
                                                      % PALETTE_COUNT;
            vram8[tile_map_pkg::WIN_MAP_BASE + a]   = 8'h00;  // empty tile 0
            vram8[tile_map_pkg::WIN_COLOR_BASE + a] = 8'h00;
        end
        vram8[tile_map_pkg::SCROLL_ADDR] = 8'h00;
        for (a = 0; a < tile_map_pkg::PATTERN_WORDS_PER_TILE; a++) begin
            vram32[a] = '0;
        end
        // even palettes get a black entry 0 so the window can be transparent
        for (a = 0; a < PALETTE_COUNT; a += 2) begin
            vram32[tile_map_pkg::PALETTE_BASE + a][31:24] = 8'h00;
        end
    endtask

    task automatic load_window_and_scroll();
        int a;
        for (a = 0; a < (H_RES / TP) * (V_RES / TP); a++) begin
            lcg_state = lcg_step(lcg_state);
            vram8[tile_map_pkg::WIN_MAP_BASE + a]   = lcg_state[31:24];
            vram8[tile_map_pkg::WIN_COLOR_BASE + a] = lcg_state[15:8] % PALETTE_COUNT;
        end
        vram8[tile_map_pkg::SCROLL_ADDR] = 8'(SCROLL_TILES);
    endtask

    initial begin
        vga_clk = 1'b0;
        forever #50 vga_clk = ~vga_clk;
    end

    // synchronous read: address of one cycle, data in the next
    initial begin
        logic [AW-1:0] rd_addr8;
        logic [AW-1:0] rd_addr32;
        i_vram8_q  = '0;
        i_vram32_q = '0;
        forever begin
            @(negedge vga_clk);
            rd_addr8  = o_vram8_addr;
            rd_addr32 = o_vram32_addr;
            @(posedge vga_clk);
            #DRIVE_DELAY;
            i_vram8_q  = vram8[rd_addr8];
            i_vram32_q = vram32[rd_addr32];
        end
    end

    // frame 0 is background only, frame 1 adds the window and a scroll
    always @(negedge vga_clk) begin
        int    x;
        int    y;
        int    scroll;
        int    colour;
        string name;
        if (!i_reset && o_de) begin
            x = pix_count % H_RES;
            y = (pix_count / H_RES) % V_RES;
            if (pix_count < FRAME_PIXELS) begin
                scroll = 0;
                name   = "bg_only";
            end else begin
                scroll = SCROLL_TILES;
                name   = "window_scroll";
            end
            check_rgb(name, expected_pixel(x, y, scroll), o_rgb);
            if (x == 0) begin  // BG_COLOR slot of tile 1
                check_addr("fetch_bg_color",
                           bg_map_addr(tile_map_pkg::BG_COLOR_BASE, TP, y, scroll), o_vram8_addr);
                addr_checks++;
            end else if (x == 1) begin  // BG_PALETTE slot of tile 1
                colour = vram8[bg_map_addr(tile_map_pkg::BG_COLOR_BASE, TP, y, scroll)];
                check_addr("fetch_bg_palette", AW'(tile_map_pkg::PALETTE_BASE + colour),
                           o_vram32_addr);
                addr_checks++;
            end else if (x == 2) begin  // WIN_TILE slot of tile 1
                check_addr("fetch_win_map",
                           win_map_addr(tile_map_pkg::WIN_MAP_BASE, TP, y), o_vram8_addr);
                addr_checks++;
            end
            pix_count++;
        end
    end

    // failures of the bound output assertions
    always @(negedge vga_clk) begin
        if (uut.u_props.fail_count != 0) begin
            $display("an assertion on the video outputs failed");
            $display("Test failed");
            $fatal(1, "simulation stopped on an assertion failure");
        end
    end

    always @(posedge vga_clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: two frames not completed within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    initial begin
        i_reset     = 1'b1;
        lcg_state   = 32'h35f26ae2;
        pix_count   = 0;
        addr_checks = 0;
        cycle_count = 0;
        fill_vram();
        repeat (16) @(posedge vga_clk);
        #DRIVE_DELAY;
        i_reset = 1'b0;
        @(negedge vga_clk);
        check_bit("reset_hsync", 1'b1, o_hsync);
        check_bit("reset_vsync", 1'b1, o_vsync);
        check_bit("reset_de", 1'b0, o_de);
        check_rgb("reset_rgb", 8'h00, o_rgb);
        wait (pix_count == FRAME_PIXELS);
        load_window_and_scroll();  // vertical blanking, before the next scroll read
        wait (pix_count == 2 * FRAME_PIXELS);
        @(negedge vga_clk);
        if (uut.u_props.fail_count != 0) begin
            $display("%0d assertion failures on the video outputs", uut.u_props.fail_count);
            $display("Test failed");
        end else if (addr_checks == 6 * V_RES) begin
            $display("Test passed");
        end else begin
            $display("only %0d of %0d fetch address checks ran", addr_checks, 6 * V_RES);
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* list.f */
hw/video_timing_pkg.sv
hw/tile_map_pkg.sv
hw/raster_timing.sv
hw/tile_fetch_sequencer.sv
hw/tile_row_decoder.sv
hw/plane_mixer.sv
hw/bgw_renderer_top.sv
verification/bgw_renderer_properties.sv
verification/bgw_renderer_tb.sv

/* Bender.yml */
package:
  name: bgw_renderer

sources:
  - files:
      - hw/video_timing_pkg.sv
      - hw/tile_map_pkg.sv
      - hw/raster_timing.sv
      - hw/tile_fetch_sequencer.sv
      - hw/tile_row_decoder.sv
      - hw/plane_mixer.sv
      - hw/bgw_renderer_top.sv
  - target: test
    files:
      - verification/bgw_renderer_properties.sv
      - verification/bgw_renderer_tb.sv
